//--- hdl/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;   // default, overridden from the top
    localparam int ROB_DEPTH = 16;
    localparam int RS_DEPTH  = 4;

    typedef logic [5:0] tag_t;       // tag 0 is hardwired zero
    typedef logic [3:0] rob_idx_t;
    typedef logic [4:0] areg_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL
    } op_e;

    localparam logic [6:0] OPC_RTYPE     = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE     = 7'b0010011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // one instruction word, seen as R or I format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            areg_t      rs2;
            areg_t      rs1;
            logic [2:0] funct3;
            areg_t      rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            areg_t       rs1;
            logic [2:0]  funct3;
            areg_t       rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

//--- hdl/ooo_if.sv
// one result bus per execution unit
interface result_if;
    import ooo_pkg::*;

    logic            valid;   // single-cycle pulse
    tag_t            tag;
    rob_idx_t        rob;
    logic [XLEN-1:0] value;

    modport producer (output valid, tag, rob, value);
    modport consumer (input valid, tag, rob, value);
endinterface

interface dispatch_if;
    import ooo_pkg::*;

    logic            valid;
    op_e             op;
    tag_t            src1;
    tag_t            src2;
    logic            rdy1;
    logic            rdy2;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    tag_t            dst;
    rob_idx_t        rob;
    logic            full;

    modport source (output valid, op, src1, src2, rdy1, rdy2, imm, use_imm, dst, rob,
                    input full);
    modport sink (input valid, op, src1, src2, rdy1, rdy2, imm, use_imm, dst, rob,
                  output full);
endinterface

//--- hdl/rename_unit.sv
module rename_unit #(
    parameter int PHYS_REGS = ooo_pkg::PHYS_REGS
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_req,
    input  logic [31:0]          instr,
    output logic                 instr_ack,
    dispatch_if.source           alu_disp,
    dispatch_if.source           mul_disp,
    output logic                 rob_alloc,
    output ooo_pkg::areg_t       rob_alloc_rd,
    output ooo_pkg::tag_t        rob_alloc_old,
    input  ooo_pkg::rob_idx_t    rob_tail,
    input  logic                 rob_full,
    input  logic                 free_valid,
    input  ooo_pkg::tag_t        free_tag,
    output ooo_pkg::tag_t        lookup1,
    output ooo_pkg::tag_t        lookup2,
    input  logic                 rdy1,
    input  logic                 rdy2,
    output logic                 alloc_valid,
    output ooo_pkg::tag_t        alloc_tag
);
    import ooo_pkg::*;

    localparam int FW = $clog2(PHYS_REGS);
    localparam logic [FW:0] FREE_INIT = (FW + 1)'(PHYS_REGS - ARCH_REGS);

    instr_u          iw;
    op_e             op;
    areg_t           rd;
    logic            is_mul, use_imm, need_tag, target_full, accept;
    logic [XLEN-1:0] imm;
    tag_t            dst;
    tag_t            rat [ARCH_REGS];
    tag_t            fl [PHYS_REGS];     // free list ring
    logic [FW-1:0]   fl_head, fl_tail;
    logic [FW:0]     fl_count;

    assign iw      = instr;
    assign rd      = iw.r.rd;
    assign use_imm = iw.i.opcode == OPC_ITYPE;
    assign is_mul  = iw.r.opcode == OPC_RTYPE && iw.r.funct7 == FUNCT7_MULDIV;
    assign imm     = {{(XLEN - 12){iw.i.imm[11]}}, iw.i.imm};

    always_comb begin
        case (iw.r.funct3)
            3'b100:  op = OP_XOR;
            3'b110:  op = OP_OR;
            3'b111:  op = OP_AND;
            default: op = (!use_imm && iw.r.funct7[5]) ? OP_SUB : OP_ADD;
        endcase
        if (is_mul) begin
            op = OP_MUL;
        end
    end

    assign need_tag    = rd != '0;   // x0 never takes a tag
    assign dst         = need_tag ? fl[fl_head] : '0;
    assign lookup1     = rat[iw.i.rs1];
    assign lookup2     = use_imm ? '0 : rat[iw.r.rs2];
    assign target_full = is_mul ? mul_disp.full : alu_disp.full;
    assign accept      = instr_req && !instr_ack && !rob_full && !target_full &&
                         (!need_tag || fl_count != '0);

    assign rob_alloc     = accept;
    assign rob_alloc_rd  = rd;
    assign rob_alloc_old = rat[rd];
    assign alloc_valid   = accept && need_tag;
    assign alloc_tag     = dst;

    assign alu_disp.valid   = accept && !is_mul;
    assign alu_disp.op      = op;
    assign alu_disp.src1    = lookup1;
    assign alu_disp.src2    = lookup2;
    assign alu_disp.rdy1    = rdy1;
    assign alu_disp.rdy2    = rdy2;
    assign alu_disp.imm     = imm;
    assign alu_disp.use_imm = use_imm;
    assign alu_disp.dst     = dst;
    assign alu_disp.rob     = rob_tail;

    assign mul_disp.valid   = accept && is_mul;
    assign mul_disp.op      = op;
    assign mul_disp.src1    = lookup1;
    assign mul_disp.src2    = lookup2;
    assign mul_disp.rdy1    = rdy1;
    assign mul_disp.rdy2    = rdy2;
    assign mul_disp.imm     = imm;
    assign mul_disp.use_imm = use_imm;
    assign mul_disp.dst     = dst;
    assign mul_disp.rob     = rob_tail;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_ack <= 1'b0;
            fl_head   <= '0;
            fl_tail   <= FREE_INIT[FW-1:0];
            fl_count  <= FREE_INIT;
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= tag_t'(i);   // identity map
            end
            for (int i = 0; i < PHYS_REGS; i++) begin
                fl[i] <= tag_t'(ARCH_REGS + i);
            end
        end else begin
            if (accept) begin
                instr_ack <= 1'b1;
            end else if (!instr_req) begin
                instr_ack <= 1'b0;   // four-phase return
            end
            if (alloc_valid) begin
                rat[rd] <= dst;
                fl_head <= fl_head + 1'b1;
            end
            if (free_valid) begin
                fl[fl_tail] <= free_tag;
                fl_tail     <= fl_tail + 1'b1;
            end
            case ({free_valid, alloc_valid})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/phys_regfile.sv
module phys_regfile #(
    parameter int PHYS_REGS = ooo_pkg::PHYS_REGS
) (
    input  logic                       clk,
    input  logic                       arst_n,
    result_if.consumer                 bus0,
    result_if.consumer                 bus1,
    input  logic                       alloc_valid,
    input  ooo_pkg::tag_t              alloc_tag,
    input  ooo_pkg::tag_t              lookup1,
    input  ooo_pkg::tag_t              lookup2,
    output logic                       rdy1,
    output logic                       rdy2,
    input  ooo_pkg::tag_t              rd_tag_a [2],
    output logic [ooo_pkg::XLEN-1:0]   rd_data_a [2],
    input  ooo_pkg::tag_t              rd_tag_m [2],
    output logic [ooo_pkg::XLEN-1:0]   rd_data_m [2]
);
    import ooo_pkg::*;

    logic [XLEN-1:0]      regs [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;

    // same-cycle broadcast counts as ready
    assign rdy1 = ready[lookup1] || (bus0.valid && bus0.tag == lookup1) ||
                  (bus1.valid && bus1.tag == lookup1);
    assign rdy2 = ready[lookup2] || (bus0.valid && bus0.tag == lookup2) ||
                  (bus1.valid && bus1.tag == lookup2);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_data_a[i] = regs[rd_tag_a[i]];
            rd_data_m[i] = regs[rd_tag_m[i]];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (bus0.valid && bus0.tag != '0) begin   // tag 0 stays zero
                regs[bus0.tag]  <= bus0.value;
                ready[bus0.tag] <= 1'b1;
            end
            if (bus1.valid && bus1.tag != '0) begin
                regs[bus1.tag]  <= bus1.value;
                ready[bus1.tag] <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/reservation_station.sv
module reservation_station #(
    parameter int RS_DEPTH = ooo_pkg::RS_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    dispatch_if.sink                   disp,
    result_if.consumer                 bus0,
    result_if.consumer                 bus1,
    output ooo_pkg::tag_t              rd_tag [2],
    input  logic [ooo_pkg::XLEN-1:0]   rd_data [2],
    input  logic                       unit_ready,
    output logic                       issue_valid,
    output ooo_pkg::op_e               issue_op,
    output logic [ooo_pkg::XLEN-1:0]   issue_a,
    output logic [ooo_pkg::XLEN-1:0]   issue_b,
    output ooo_pkg::tag_t              issue_dst,
    output ooo_pkg::rob_idx_t          issue_rob
);
    import ooo_pkg::*;

    localparam int AW = $clog2(RS_DEPTH) + 1;

    logic [RS_DEPTH-1:0] vld, rdy1, rdy2, use_imm;
    op_e                 op [RS_DEPTH];
    tag_t                src1 [RS_DEPTH];
    tag_t                src2 [RS_DEPTH];
    tag_t                dst [RS_DEPTH];
    logic [XLEN-1:0]     imm [RS_DEPTH];
    rob_idx_t            rob [RS_DEPTH];
    logic [AW-1:0]       age [RS_DEPTH];   // higher is older
    logic [AW-1:0]       best;
    logic                found, has_free;
    int                  sel, free_idx;

    always_comb begin
        found    = 1'b0;
        sel      = 0;
        best     = '0;
        has_free = 1'b0;
        free_idx = 0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (vld[i] && rdy1[i] && rdy2[i] && (!found || age[i] > best)) begin
                found = 1'b1;
                sel   = i;
                best  = age[i];
            end
        end
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!vld[i]) begin
                has_free = 1'b1;
                free_idx = i;
            end
        end
    end

    assign disp.full   = !has_free;
    assign issue_valid = found && unit_ready;
    assign issue_op    = op[sel];
    assign issue_dst   = dst[sel];
    assign issue_rob   = rob[sel];
    assign rd_tag[0]   = src1[sel];
    assign rd_tag[1]   = src2[sel];
    assign issue_a     = rd_data[0];
    assign issue_b     = use_imm[sel] ? imm[sel] : rd_data[1];   // ADDI

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld  <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if ((bus0.valid && bus0.tag == src1[i]) || (bus1.valid && bus1.tag == src1[i]))
                    rdy1[i] <= 1'b1;
                if ((bus0.valid && bus0.tag == src2[i]) || (bus1.valid && bus1.tag == src2[i]))
                    rdy2[i] <= 1'b1;
                // age is the number of younger entries still held
                if (vld[i] && disp.valid && !(issue_valid && age[i] > best)) begin
                    age[i] <= age[i] + 1'b1;
                end else if (vld[i] && !disp.valid && issue_valid && age[i] > best) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (issue_valid) begin
                vld[sel] <= 1'b0;
            end
            if (disp.valid) begin
                vld[free_idx]  <= 1'b1;
                rdy1[free_idx] <= disp.rdy1;
                rdy2[free_idx] <= disp.rdy2;
                age[free_idx]  <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp.valid) begin
            op[free_idx]      <= disp.op;
            src1[free_idx]    <= disp.src1;
            src2[free_idx]    <= disp.src2;
            dst[free_idx]     <= disp.dst;
            imm[free_idx]     <= disp.imm;
            use_imm[free_idx] <= disp.use_imm;
            rob[free_idx]     <= disp.rob;
        end
    end

endmodule

//--- hdl/int_alu.sv
module int_alu (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       issue_valid,
    input  ooo_pkg::op_e               issue_op,
    input  logic [ooo_pkg::XLEN-1:0]   issue_a,
    input  logic [ooo_pkg::XLEN-1:0]   issue_b,
    input  ooo_pkg::tag_t              issue_dst,
    input  ooo_pkg::rob_idx_t          issue_rob,
    result_if.producer                 res
);
    import ooo_pkg::*;

    logic [XLEN-1:0] result;

    always_comb begin
        case (issue_op)
            OP_SUB:  result = issue_a - issue_b;
            OP_AND:  result = issue_a & issue_b;
            OP_OR:   result = issue_a | issue_b;
            OP_XOR:  result = issue_a ^ issue_b;
            default: result = issue_a + issue_b;   // ADD, ADDI
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res.tag   <= issue_dst;
            res.rob   <= issue_rob;
            res.value <= result;
        end
    end

endmodule

//--- hdl/iter_multiplier.sv
module iter_multiplier (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       issue_valid,
    input  ooo_pkg::op_e               issue_op,
    input  logic [ooo_pkg::XLEN-1:0]   issue_a,
    input  logic [ooo_pkg::XLEN-1:0]   issue_b,
    input  ooo_pkg::tag_t              issue_dst,
    input  ooo_pkg::rob_idx_t          issue_rob,
    output logic                       ready,
    result_if.producer                 res
);
    import ooo_pkg::*;

    logic            busy, start;
    logic [4:0]      cnt;
    logic [XLEN-1:0] mcand, mplier, acc, acc_next;

    assign start    = issue_valid && issue_op == OP_MUL;
    assign ready    = !busy;
    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign res.value = acc;   // final sum sits here when valid pulses

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            res.valid <= 1'b0;
        end else begin
            res.valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == 5'd31) begin   // last of 32 steps
                    busy      <= 1'b0;
                    res.valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand   <= issue_a;
            mplier  <= issue_b;
            acc     <= '0;
            res.tag <= issue_dst;
            res.rob <= issue_rob;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

//--- hdl/reorder_buffer.sv
module reorder_buffer #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       rob_alloc,
    input  ooo_pkg::areg_t             rob_alloc_rd,
    input  ooo_pkg::tag_t              rob_alloc_old,
    output ooo_pkg::rob_idx_t          rob_tail,
    output logic                       rob_full,
    result_if.consumer                 bus0,
    result_if.consumer                 bus1,
    output logic                       commit_valid,
    output ooo_pkg::areg_t             commit_rd,
    output logic [ooo_pkg::XLEN-1:0]   commit_value,
    output logic                       free_valid,
    output ooo_pkg::tag_t              free_tag
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0] busy, done;
    areg_t                rd [ROB_DEPTH];
    tag_t                 old [ROB_DEPTH];   // previous mapping of rd
    logic [XLEN-1:0]      value [ROB_DEPTH];
    rob_idx_t             head;
    logic                 retire;

    assign rob_full = busy[rob_tail];
    assign retire   = busy[head] && done[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= '0;
            done         <= '0;
            head         <= '0;
            rob_tail     <= '0;
            commit_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            commit_valid <= retire;
            free_valid   <= retire && rd[head] != '0;
            if (bus0.valid) begin
                done[bus0.rob] <= 1'b1;
            end
            if (bus1.valid) begin
                done[bus1.rob] <= 1'b1;
            end
            if (rob_alloc) begin
                busy[rob_tail] <= 1'b1;
                done[rob_tail] <= 1'b0;
                rob_tail       <= rob_tail + 1'b1;
            end
            if (retire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            rd[rob_tail]  <= rob_alloc_rd;
            old[rob_tail] <= rob_alloc_old;
        end
        if (bus0.valid) begin
            value[bus0.rob] <= bus0.value;
        end
        if (bus1.valid) begin
            value[bus1.rob] <= bus1.value;
        end
        if (retire) begin
            commit_rd    <= rd[head];
            commit_value <= (rd[head] == '0) ? '0 : value[head];   // x0 reads zero
            free_tag     <= old[head];
        end
    end

endmodule

//--- hdl/ooo_core.sv
module ooo_core #(
    parameter int PHYS_REGS = ooo_pkg::PHYS_REGS,
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH,
    parameter int RS_DEPTH  = ooo_pkg::RS_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       instr_req,
    input  logic [31:0]                instr,
    output logic                       instr_ack,
    output logic                       commit_valid,
    output ooo_pkg::areg_t             commit_rd,
    output logic [ooo_pkg::XLEN-1:0]   commit_value
);
    import ooo_pkg::*;

    result_if   bus0 ();   // int_alu
    result_if   bus1 ();   // iter_multiplier
    dispatch_if alu_disp ();
    dispatch_if mul_disp ();

    logic            rob_alloc, rob_full, free_valid, alloc_valid;
    areg_t           rob_alloc_rd;
    tag_t            rob_alloc_old, free_tag, alloc_tag, lookup1, lookup2;
    rob_idx_t        rob_tail;
    logic            rdy1, rdy2;
    tag_t            rd_tag_a [2];
    tag_t            rd_tag_m [2];
    logic [XLEN-1:0] rd_data_a [2];
    logic [XLEN-1:0] rd_data_m [2];

    logic            alu_iv, mul_iv, mul_ready;
    op_e             alu_op, mul_op;
    logic [XLEN-1:0] alu_a, alu_b, mul_a, mul_b;
    tag_t            alu_dst, mul_dst;
    rob_idx_t        alu_rob, mul_rob;

    rename_unit #(.PHYS_REGS(PHYS_REGS)) i_rename (
        .clk, .arst_n, .instr_req, .instr, .instr_ack,
        .alu_disp, .mul_disp,
        .rob_alloc, .rob_alloc_rd, .rob_alloc_old, .rob_tail, .rob_full,
        .free_valid, .free_tag, .lookup1, .lookup2, .rdy1, .rdy2,
        .alloc_valid, .alloc_tag
    );

    phys_regfile #(.PHYS_REGS(PHYS_REGS)) i_prf (
        .clk, .arst_n, .bus0, .bus1, .alloc_valid, .alloc_tag,
        .lookup1, .lookup2, .rdy1, .rdy2,
        .rd_tag_a, .rd_data_a, .rd_tag_m, .rd_data_m
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) alu_rs (
        .clk, .arst_n, .disp(alu_disp), .bus0, .bus1,
        .rd_tag(rd_tag_a), .rd_data(rd_data_a), .unit_ready(1'b1),
        .issue_valid(alu_iv), .issue_op(alu_op), .issue_a(alu_a), .issue_b(alu_b),
        .issue_dst(alu_dst), .issue_rob(alu_rob)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) mul_rs (
        .clk, .arst_n, .disp(mul_disp), .bus0, .bus1,
        .rd_tag(rd_tag_m), .rd_data(rd_data_m), .unit_ready(mul_ready),
        .issue_valid(mul_iv), .issue_op(mul_op), .issue_a(mul_a), .issue_b(mul_b),
        .issue_dst(mul_dst), .issue_rob(mul_rob)
    );

    int_alu i_alu (
        .clk, .arst_n, .issue_valid(alu_iv), .issue_op(alu_op), .issue_a(alu_a),
        .issue_b(alu_b), .issue_dst(alu_dst), .issue_rob(alu_rob), .res(bus0)
    );

    iter_multiplier i_mul (
        .clk, .arst_n, .issue_valid(mul_iv), .issue_op(mul_op), .issue_a(mul_a),
        .issue_b(mul_b), .issue_dst(mul_dst), .issue_rob(mul_rob), .ready(mul_ready),
        .res(bus1)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
        .clk, .arst_n, .rob_alloc, .rob_alloc_rd, .rob_alloc_old, .rob_tail, .rob_full,
        .bus0, .bus1, .commit_valid, .commit_rd, .commit_value, .free_valid, .free_tag
    );

endmodule

//--- dv/tb_ooo_core.sv
module tb_ooo_core;
    import ooo_pkg::*;

    localparam int ACK_TIMEOUT    = 400;
    localparam int COMMIT_TIMEOUT = 2000;

    typedef enum {I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_MUL, I_ADDI} kind_e;

    logic            clk, arst_n, instr_req, instr_ack, commit_valid;
    logic [31:0]     instr;
    areg_t           commit_rd;
    logic [XLEN-1:0] commit_value;

    logic [31:0]     instr_q [$];
    areg_t           exp_rd_q [$];
    logic [31:0]     exp_val_q [$];
    int              gap_q [$];
    int              ack_wait [$];
    logic [31:0]     model_regs [32];   // architectural state of the reference model
    logic [31:0]     lfsr = 32'h9a1a;
    int              ncommit = 0;
    int              burst_lo, burst_hi;

    ooo_core i_ooo_core (
        .clk, .arst_n, .instr_req, .instr, .instr_ack,
        .commit_valid, .commit_rd, .commit_value
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_commit_rd(input areg_t got, input areg_t exp, input int idx);
        if (got !== exp) begin
            $display("ERR %0t: commit %0d has rd x%0d, expected x%0d", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                               input int idx);
        if (got !== exp) begin
            $display("ERR %0t: commit %0d value %h, expected %h", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [31:0] encode(input kind_e k, input areg_t rd, input areg_t rs1,
                                           input logic [11:0] b);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'b0000000;
        f3 = 3'b000;
        case (k)
            I_SUB:   f7 = 7'b0100000;
            I_AND:   f3 = 3'b111;
            I_OR:    f3 = 3'b110;
            I_XOR:   f3 = 3'b100;
            I_MUL:   f7 = 7'b0000001;
            default: ;
        endcase
        if (k == I_ADDI)
            return {b, rs1, 3'b000, rd, 7'b0010011};
        return {f7, b[4:0], rs1, f3, rd, 7'b0110011};
    endfunction

    // b is rs2 for R-type, the immediate for ADDI
    task automatic add_op(input kind_e k, input int rd, input int rs1, input int b,
                          input bit burst);
        logic [31:0] x, y, r;
        x = model_regs[areg_t'(rs1)];
        y = (k == I_ADDI) ? {{20{b[11]}}, b[11:0]} : model_regs[areg_t'(b)];
        case (k)
            I_SUB:   r = x - y;
            I_AND:   r = x & y;
            I_OR:    r = x | y;
            I_XOR:   r = x ^ y;
            I_MUL:   r = x * y;   // low word only
            default: r = x + y;
        endcase
        if (rd == 0)
            r = '0;
        else
            model_regs[areg_t'(rd)] = r;
        instr_q.push_back(encode(k, areg_t'(rd), areg_t'(rs1), b[11:0]));
        exp_rd_q.push_back(areg_t'(rd));
        exp_val_q.push_back(r);
        gap_q.push_back(burst ? 0 : rand_bits(2));
    endtask

    task automatic build_table();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int r = 1; r <= 5; r++) begin
            add_op(I_ADDI, r, r, 0, 0);   // reset values
        end
        add_op(I_ADDI, 1, 0, 100, 0);
        add_op(I_ADDI, 2, 0, -7, 0);
        add_op(I_ADDI, 3, 0, 'h5a5, 0);
        add_op(I_ADD, 4, 1, 2, 0);
        add_op(I_SUB, 5, 2, 1, 0);
        add_op(I_AND, 6, 3, 2, 0);
        add_op(I_OR, 7, 3, 1, 0);
        add_op(I_XOR, 8, 3, 2, 0);
        add_op(I_ADDI, 9, 4, 2047, 0);
        add_op(I_MUL, 10, 1, 2, 0);       // mul into alu chain
        add_op(I_ADD, 11, 10, 3, 0);
        add_op(I_MUL, 12, 11, 11, 0);
        add_op(I_SUB, 13, 12, 10, 0);
        add_op(I_MUL, 14, 3, 3, 0);
        add_op(I_XOR, 15, 1, 3, 0);       // finishes before x14
        add_op(I_ADD, 16, 2, 2, 0);
        add_op(I_ADD, 17, 14, 15, 0);
        burst_lo = instr_q.size();
        add_op(I_MUL, 18, 1, 3, 1);
        add_op(I_MUL, 19, 2, 2, 1);
        add_op(I_MUL, 20, 18, 4, 1);
        add_op(I_MUL, 21, 19, 5, 1);
        add_op(I_MUL, 22, 7, 8, 1);
        add_op(I_MUL, 23, 20, 21, 1);
        burst_hi = instr_q.size() - 1;
        add_op(I_ADDI, 0, 1, 5, 0);
        add_op(I_ADD, 0, 1, 2, 0);
        add_op(I_MUL, 0, 3, 3, 0);
        add_op(I_ADD, 24, 0, 1, 0);
        add_op(I_ADDI, 25, 0, 0, 0);
        add_op(I_XOR, 26, 0, 5, 0);
    endtask

    task automatic wait_ack(input logic level, input int idx, output int cycles);
        cycles = 0;
        while (instr_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("timeout: instr_ack never went to %0b for entry %0d", level, idx);
                abort_run();
            end
        end
    endtask

    // commits arrive in table order
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            if (ncommit >= instr_q.size()) begin
                $display("unexpected commit of x%0d after the last instruction", commit_rd);
                abort_run();
            end else begin
                check_commit_rd(commit_rd, exp_rd_q[ncommit], ncommit);
                check_value(commit_value, exp_val_q[ncommit], ncommit);
                ncommit++;
            end
        end
    end

    initial begin
        int   waited;
        int   cycles;
        logic stalled;
        arst_n    = 1'b0;
        instr_req = 1'b0;
        instr     = '0;
        build_table();
        repeat (3) begin
            @(negedge clk);
            check_flag(instr_ack, 1'b0, "instr_ack in reset");
            check_flag(commit_valid, 1'b0, "commit_valid in reset");
        end
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_flag(instr_ack, 1'b0, "instr_ack after reset");
            check_flag(commit_valid, 1'b0, "commit_valid after reset");
        end

        for (int i = 0; i < instr_q.size(); i++) begin
            instr     = instr_q[i];
            instr_req = 1'b1;
            wait_ack(1'b1, i, waited);
            ack_wait.push_back(waited);
            instr_req = 1'b0;
            wait_ack(1'b0, i, waited);
            repeat (gap_q[i]) @(negedge clk);
        end

        stalled = 1'b0;
        for (int i = burst_lo; i <= burst_hi; i++) begin
            if (ack_wait[i] > 8)
                stalled = 1'b1;   // station full, ack held back
        end
        check_flag(stalled, 1'b1, "ack back-pressure in mul burst");

        cycles = 0;
        while (ncommit < instr_q.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > COMMIT_TIMEOUT) begin
                $display("timeout: only %0d of %0d instructions committed",
                         ncommit, instr_q.size());
                abort_run();
            end
        end
        repeat (5) @(negedge clk);   // catch stray commits
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
hdl/ooo_pkg.sv
hdl/ooo_if.sv
hdl/rename_unit.sv
hdl/phys_regfile.sv
hdl/reservation_station.sv
hdl/int_alu.sv
hdl/iter_multiplier.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
dv/tb_ooo_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ooo_core -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
